//--- mdio_frame_pkg.sv
package mdio_frame_pkg;

    localparam int MDIO_PREAMBLE_BITS = 32;             // leading ones before start
    localparam int MDIO_FRAME_BITS    = 32;             // start through data
    localparam int MDIO_DATA_BITS     = 16;
    localparam int MDIO_TOTAL_BITS    = MDIO_PREAMBLE_BITS + MDIO_FRAME_BITS;
    localparam int MDIO_BIT_CNT_W     = $clog2(MDIO_TOTAL_BITS);
    localparam int MDIO_DATA_POS      = MDIO_TOTAL_BITS - MDIO_DATA_BITS;  // first data bit
    localparam int MDIO_RELEASE_POS   = MDIO_DATA_POS - 1;                 // second ta bit

    localparam logic [1:0] MDIO_START    = 2'b01;       // clause 22 start
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0] MDIO_OP_READ  = 2'b10;
    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;       // driven ta on writes

    typedef logic [4:0]                reg_addr_bits_t;
    typedef reg_addr_bits_t            mdio_reg_addr_t;  // also used for phy address
    typedef logic [MDIO_DATA_BITS-1:0] mdio_data_t;

    // one frame word, built by fields and shifted out raw msb first
    typedef union packed {
        struct packed {
            logic [1:0]     start;
            logic [1:0]     op;
            mdio_reg_addr_t phy_addr;
            mdio_reg_addr_t reg_addr;
            logic [1:0]     ta;
            mdio_data_t     data;
        } f;
        logic [MDIO_FRAME_BITS-1:0] raw;
    } mdio_frame_u;

endpackage

//--- phy_board_pkg.sv
package phy_board_pkg;

    // bus address of the single external phy
    localparam logic [4:0] PHY_ADDR = 5'd0;

    localparam mdio_frame_pkg::mdio_reg_addr_t REG_BMCR = 5'd0;   // basic control
    localparam mdio_frame_pkg::mdio_reg_addr_t REG_BMSR = 5'd1;   // basic status
    localparam mdio_frame_pkg::mdio_reg_addr_t REG_ANAR = 5'd4;   // an advertisement

    localparam int BMSR_AN_DONE_BIT = 5;                // an complete flag

    localparam int INIT_WRITES = 3;
    localparam int INIT_IDX_W  = $clog2(INIT_WRITES + 1);  // one extra for poll phase

    // bring-up table, walked in order
    localparam mdio_frame_pkg::mdio_reg_addr_t INIT_REG [INIT_WRITES] = '{
        REG_ANAR,                                       // advertise
        REG_BMCR,                                       // an enable
        REG_BMCR                                        // an restart
    };
    localparam mdio_frame_pkg::mdio_data_t INIT_DATA [INIT_WRITES] = '{
        16'h01E1,                                       // 100/10 fd+hd, 802.3 selector
        16'h1000,                                       // bit 12 an enable
        16'h1200                                        // an enable + restart
    };

    localparam int MDC_HALF_DIV   = 4;                  // sys clocks per mdc half
    localparam int MDC_DIV_W      = $clog2(2 * MDC_HALF_DIV);
    localparam int MDI_SAMPLE_LAG = 3;                  // pin reg + two sync flops

    localparam int PHY_RST_CYCLES    = 64;              // phy reset low time
    localparam int PHY_SETTLE_CYCLES = 32;              // quiet time after release
    localparam int RST_CNT_W = $clog2(PHY_RST_CYCLES + PHY_SETTLE_CYCLES + 1);

endpackage

//--- phy_init_seq.sv
`timescale 1ns/1ps

module phy_init_seq
    import mdio_frame_pkg::*;
    import phy_board_pkg::*;
(
    input  logic           FPGA_SYS_CLK,
    input  logic           FPGA_SYS_RST_N,
    input  logic           i_phy_ready,       // phy out of reset and settled
    input  logic           i_reg_busy,
    input  mdio_data_t     i_reg_rdata,
    output logic           o_reg_wr,
    output logic           o_reg_rd,
    output mdio_reg_addr_t o_reg_addr,
    output mdio_data_t     o_reg_wdata,
    output logic           o_init_done
);

    logic [INIT_IDX_W-1:0] wr_idx;            // table position
    logic                  pend;              // command out, frame not finished
    logic                  busy_q;
    logic                  polling;           // table done, polling bmsr
    logic                  frame_done;
    logic                  an_done;
    logic                  can_issue;

    assign polling    = wr_idx == INIT_IDX_W'(INIT_WRITES);
    assign frame_done = busy_q & ~i_reg_busy;             // busy falling edge
    assign an_done    = i_reg_rdata[BMSR_AN_DONE_BIT];
    assign can_issue  = i_phy_ready & ~pend & ~i_reg_busy & ~o_init_done;

    // control state
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            wr_idx      <= '0;
            pend        <= 1'b0;
            busy_q      <= 1'b0;
            o_reg_wr    <= 1'b0;
            o_reg_rd    <= 1'b0;
            o_init_done <= 1'b0;
        end else begin
            busy_q   <= i_reg_busy;
            o_reg_wr <= 1'b0;                             // single cycle strobes
            o_reg_rd <= 1'b0;
            if (can_issue) begin
                pend <= 1'b1;
                if (polling) begin
                    o_reg_rd <= 1'b1;                     // bmsr poll
                end else begin
                    o_reg_wr <= 1'b1;                     // next table entry
                end
            end else if (frame_done) begin
                pend <= 1'b0;
                if (!polling) begin
                    wr_idx <= wr_idx + 1'b1;
                end else if (an_done) begin
                    o_init_done <= 1'b1;                  // sticky, no more frames
                end
            end
        end
    end

    // command payload, only meaningful with a strobe
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (can_issue) begin
            if (polling) begin
                o_reg_addr  <= REG_BMSR;
                o_reg_wdata <= '0;
            end else begin
                o_reg_addr  <= INIT_REG[wr_idx];
                o_reg_wdata <= INIT_DATA[wr_idx];
            end
        end
    end

endmodule

//--- mdio_master.sv
`timescale 1ns/1ps

module mdio_master
    import mdio_frame_pkg::*;
    import phy_board_pkg::*;
(
    input  logic           FPGA_SYS_CLK,
    input  logic           FPGA_SYS_RST_N,
    input  logic           i_reg_wr,
    input  logic           i_reg_rd,
    input  mdio_reg_addr_t i_reg_addr,
    input  mdio_data_t     i_reg_wdata,
    input  logic           i_mdi,             // already synchronized
    output logic           o_reg_busy,
    output mdio_data_t     o_reg_rdata,
    output logic           o_mdc,
    output logic           o_mdo,
    output logic           o_mdo_oe
);

    logic [MDC_DIV_W-1:0]      div_cnt;       // position in one mdc period
    logic [MDIO_BIT_CNT_W-1:0] bit_cnt;       // preamble + frame bit index
    logic [MDIO_BIT_CNT_W-1:0] nxt_bit;
    logic                      rd_q;          // frame in flight is a read
    mdio_frame_u               cmd_frame;
    mdio_frame_u               frame_q;       // shift word
    logic                      accept;
    logic                      rise_stb;      // mdc goes high next
    logic                      bit_end;       // mdc goes low next
    logic                      samp_stb;      // synced mdi matches pin at mdc rise
    logic                      last_bit;

    always_comb begin
        cmd_frame.f.start    = MDIO_START;
        cmd_frame.f.op       = i_reg_rd ? MDIO_OP_READ : MDIO_OP_WRITE;
        cmd_frame.f.phy_addr = PHY_ADDR;
        cmd_frame.f.reg_addr = i_reg_addr;
        cmd_frame.f.ta       = MDIO_TA_WRITE;  // released on reads anyway
        cmd_frame.f.data     = i_reg_wdata;
    end

    assign accept   = (i_reg_wr | i_reg_rd) & ~o_reg_busy;
    assign rise_stb = o_reg_busy & (div_cnt == MDC_DIV_W'(MDC_HALF_DIV - 1));
    assign bit_end  = o_reg_busy & (div_cnt == MDC_DIV_W'(2 * MDC_HALF_DIV - 1));
    assign samp_stb = o_reg_busy & (div_cnt == MDC_DIV_W'(MDC_HALF_DIV - 1 + MDI_SAMPLE_LAG));
    assign last_bit = bit_cnt == MDIO_BIT_CNT_W'(MDIO_TOTAL_BITS - 1);
    assign nxt_bit  = bit_cnt + 1'b1;

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            o_reg_busy <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            rd_q       <= 1'b0;
            o_mdc      <= 1'b0;
            o_mdo      <= 1'b1;                   // idle line high
            o_mdo_oe   <= 1'b0;
        end else if (accept) begin
            o_reg_busy <= 1'b1;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            rd_q       <= i_reg_rd;
            o_mdo      <= 1'b1;                   // first preamble one
            o_mdo_oe   <= 1'b1;
        end else if (o_reg_busy) begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (rise_stb) o_mdc <= 1'b1;
            if (bit_end) begin
                o_mdc   <= 1'b0;                  // mdo only moves with mdc falling
                bit_cnt <= nxt_bit;
                if (last_bit) begin
                    o_reg_busy <= 1'b0;
                    o_mdo      <= 1'b1;
                    o_mdo_oe   <= 1'b0;
                end else begin
                    o_mdo    <= (nxt_bit < MDIO_BIT_CNT_W'(MDIO_PREAMBLE_BITS)) ?
                                1'b1 : frame_q.raw[MDIO_FRAME_BITS-1];
                    o_mdo_oe <= ~(rd_q && nxt_bit >= MDIO_BIT_CNT_W'(MDIO_RELEASE_POS));
                end
            end
        end
    end

    // frame word, shifted once per bit after preamble
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (accept) begin
            frame_q <= cmd_frame;
        end else if (bit_end && nxt_bit >= MDIO_BIT_CNT_W'(MDIO_PREAMBLE_BITS)) begin
            frame_q.raw <= {frame_q.raw[MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

    // read data, msb first
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (samp_stb && rd_q && bit_cnt >= MDIO_BIT_CNT_W'(MDIO_DATA_POS)) begin
            o_reg_rdata <= {o_reg_rdata[MDIO_DATA_BITS-2:0], i_mdi};
        end
    end

endmodule

//--- phy_pin_ctrl.sv
`timescale 1ns/1ps

module phy_pin_ctrl
    import phy_board_pkg::*;
(
    input  logic FPGA_SYS_CLK,
    input  logic FPGA_SYS_RST_N,
    input  logic i_mdc,
    input  logic i_mdo,
    input  logic i_mdo_oe,
    input  logic i_phy_mdio_i,              // raw pin, async to us
    output logic o_mdi,
    output logic o_phy_ready,               // level, management access allowed
    output logic o_phy_rst_n,
    output logic o_phy_mdc,
    output logic o_phy_mdio_o,
    output logic o_phy_mdio_oe
);

    logic [RST_CNT_W-1:0] rst_cnt;          // reset low time then settle window
    logic                 mdi_meta;
    logic                 mdi_sync;

    // phy reset release and settle timing
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            rst_cnt     <= '0;
            o_phy_rst_n <= 1'b0;
            o_phy_ready <= 1'b0;
        end else begin
            if (!o_phy_ready) rst_cnt <= rst_cnt + 1'b1;   // freeze once ready
            if (rst_cnt == RST_CNT_W'(PHY_RST_CYCLES - 1)) begin
                o_phy_rst_n <= 1'b1;
            end
            if (rst_cnt == RST_CNT_W'(PHY_RST_CYCLES + PHY_SETTLE_CYCLES - 1)) begin
                o_phy_ready <= 1'b1;
            end
        end
    end

    // management pins, one cycle behind the master
    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            o_phy_mdc     <= 1'b0;
            o_phy_mdio_o  <= 1'b1;
            o_phy_mdio_oe <= 1'b0;
        end else begin
            o_phy_mdc     <= i_mdc;
            o_phy_mdio_o  <= i_mdo;
            o_phy_mdio_oe <= i_mdo_oe & o_phy_rst_n;   // never drive into a held phy
        end
    end

    // two flop mdio input sync
    always_ff @(posedge FPGA_SYS_CLK) begin
        mdi_meta <= i_phy_mdio_i;
        mdi_sync <= mdi_meta;
    end

    assign o_mdi = mdi_sync;

endmodule

//--- tsn_phy_mgmt_top.sv
`timescale 1ns/1ps

module tsn_phy_mgmt_top
    import mdio_frame_pkg::*;
(
    input  logic FPGA_SYS_CLK,              // system clock
    input  logic FPGA_SYS_RST_N,
    input  logic i_phy_mdio_i,              // mdio pin in, tristate outside
    output logic o_phy_rst_n,
    output logic o_phy_mdc,
    output logic o_phy_mdio_o,
    output logic o_phy_mdio_oe,
    output logic o_init_done
);

    logic           smi_mdc;
    logic           smi_mdo;
    logic           smi_oe;
    logic           smi_mdi;                // synced back from the pin
    logic           phy_ready;
    logic           reg_wr;
    logic           reg_rd;
    logic           reg_busy;
    mdio_reg_addr_t reg_addr;
    mdio_data_t     reg_data_in;            // write data to master
    mdio_data_t     reg_data_out;           // read data from master

    phy_init_seq phy_init_seq_inst (
        .FPGA_SYS_CLK  (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N(FPGA_SYS_RST_N),
        .i_phy_ready   (phy_ready),
        .i_reg_busy    (reg_busy),
        .i_reg_rdata   (reg_data_out),
        .o_reg_wr      (reg_wr),
        .o_reg_rd      (reg_rd),
        .o_reg_addr    (reg_addr),
        .o_reg_wdata   (reg_data_in),
        .o_init_done   (o_init_done)
    );

    mdio_master mdio_master_inst (
        .FPGA_SYS_CLK  (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N(FPGA_SYS_RST_N),
        .i_reg_wr      (reg_wr),
        .i_reg_rd      (reg_rd),
        .i_reg_addr    (reg_addr),
        .i_reg_wdata   (reg_data_in),
        .i_mdi         (smi_mdi),
        .o_reg_busy    (reg_busy),
        .o_reg_rdata   (reg_data_out),
        .o_mdc         (smi_mdc),
        .o_mdo         (smi_mdo),
        .o_mdo_oe      (smi_oe)
    );

    phy_pin_ctrl phy_pin_ctrl_inst (
        .FPGA_SYS_CLK  (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N(FPGA_SYS_RST_N),
        .i_mdc         (smi_mdc),
        .i_mdo         (smi_mdo),
        .i_mdo_oe      (smi_oe),
        .i_phy_mdio_i  (i_phy_mdio_i),
        .o_mdi         (smi_mdi),
        .o_phy_ready   (phy_ready),
        .o_phy_rst_n   (o_phy_rst_n),
        .o_phy_mdc     (o_phy_mdc),
        .o_phy_mdio_o  (o_phy_mdio_o),
        .o_phy_mdio_oe (o_phy_mdio_oe)
    );

endmodule

//--- tb_mdio_assertions.sv
`timescale 1ns/1ps

module tb_mdio_assertions
    import mdio_frame_pkg::*;
    import phy_board_pkg::*;
(
    input logic FPGA_SYS_CLK,
    input logic FPGA_SYS_RST_N,
    input logic o_phy_rst_n,
    input logic o_phy_mdc,
    input logic o_phy_mdio_o,
    input logic o_phy_mdio_oe,
    input logic o_init_done
);

    int          fail_cnt = 0;            // read by the testbench top
    logic [15:0] rel_cnt;                 // cycles since reset release, saturating
    logic [7:0]  run_len;                 // cycles mdc held its level
    logic [5:0]  rise_cnt;                // mdc rises in the current frame
    logic [1:0]  op_bits;                 // opcode seen on the pin
    logic        mdc_q;
    logic        mdo_q;
    logic        done_q;
    logic        mdc_rise;
    logic        rd_frame;

    assign mdc_rise = o_phy_mdc & ~mdc_q;
    assign rd_frame = op_bits == MDIO_OP_READ;

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            rel_cnt  <= '0;
            run_len  <= '0;
            rise_cnt <= '0;
            op_bits  <= '0;
            mdc_q    <= 1'b0;
            mdo_q    <= 1'b1;
            done_q   <= 1'b0;
        end else begin
            mdc_q  <= o_phy_mdc;
            mdo_q  <= o_phy_mdio_o;
            done_q <= o_init_done;
            if (rel_cnt != 16'hffff) rel_cnt <= rel_cnt + 1'b1;
            if (o_phy_mdc != mdc_q) run_len <= 8'd1;
            else if (run_len != 8'hff) run_len <= run_len + 1'b1;
            if (mdc_rise) begin
                rise_cnt <= rise_cnt + 1'b1;          // wraps at 64 bits per frame
                if (rise_cnt == 6'd34 || rise_cnt == 6'd35) op_bits <= {op_bits[0], o_phy_mdio_o};
            end
        end
    end

    // phy reset low time, counted from reset release
    rst_low: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        rel_cnt < 16'(PHY_RST_CYCLES) |-> !o_phy_rst_n)
        else begin fail_cnt++; $error("phy reset released early"); end
    rst_rel: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        rel_cnt == 16'(PHY_RST_CYCLES) |-> o_phy_rst_n)
        else begin fail_cnt++; $error("phy reset not released on time"); end
    pins_idle: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        !o_phy_rst_n |-> !o_phy_mdio_oe && !o_phy_mdc && !o_init_done)
        else begin fail_cnt++; $error("management pins active while phy held in reset"); end

    mdc_high: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (!o_phy_mdc && mdc_q) |-> run_len == 8'(MDC_HALF_DIV))
        else begin fail_cnt++; $error("mdc high half period wrong"); end
    mdc_low: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (mdc_rise && rise_cnt != 6'd0) |-> run_len == 8'(MDC_HALF_DIV))
        else begin fail_cnt++; $error("mdc low half period wrong"); end
    mdo_stable: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (o_phy_mdio_o != mdo_q) |-> !o_phy_mdc)
        else begin fail_cnt++; $error("mdio changed while mdc high"); end

    rd_release: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (mdc_rise && rd_frame && rise_cnt >= 6'(MDIO_RELEASE_POS)) |-> !o_phy_mdio_oe)
        else begin fail_cnt++; $error("mdio driven during read turnaround or data"); end

    done_quiet: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        o_init_done |-> !o_phy_mdc)
        else begin fail_cnt++; $error("mdc activity after init done"); end
    done_sticky: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        done_q |-> o_init_done)
        else begin fail_cnt++; $error("init done dropped"); end

endmodule

bind tsn_phy_mgmt_top tb_mdio_assertions mdio_chk (
    .FPGA_SYS_CLK  (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N(FPGA_SYS_RST_N),
    .o_phy_rst_n   (o_phy_rst_n),
    .o_phy_mdc     (o_phy_mdc),
    .o_phy_mdio_o  (o_phy_mdio_o),
    .o_phy_mdio_oe (o_phy_mdio_oe),
    .o_init_done   (o_init_done)
);

//--- tb_tsn_phy_mgmt.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end
endmodule

module tb_tsn_phy_mgmt
    import mdio_frame_pkg::*;
    import phy_board_pkg::*;
;

    localparam int RST_CYCLES   = 16;
    localparam int FRAME_CYCLES = MDIO_TOTAL_BITS * 2 * MDC_HALF_DIV;   // 512
    localparam int LIMIT_CYCLES = (RST_CYCLES + PHY_RST_CYCLES + PHY_SETTLE_CYCLES
                                  + (INIT_WRITES + 5) * FRAME_CYCLES) * 2;
    localparam mdio_data_t BMSR_BUSY = 16'h7809;   // an complete clear
    localparam mdio_data_t BMSR_DONE = 16'h7829;   // an complete set

    logic        FPGA_SYS_CLK;
    logic        FPGA_SYS_RST_N;
    logic        i_phy_mdio_i;
    logic        o_phy_rst_n;
    logic        o_phy_mdc;
    logic        o_phy_mdio_o;
    logic        o_phy_mdio_oe;
    logic        o_init_done;

    int          seed = 32'h7975_c219;
    int          n_busy;                 // polls answered with an not done
    int          bit_idx = 0;
    int          wr_cnt = 0;
    int          rd_cnt = 0;
    logic        rd_frame = 1'b0;
    logic        bus_bit;
    logic        mdio_next = 1'b1;       // phy drive value, moved to pin on clk fall
    mdio_data_t  reply;
    mdio_frame_u frame_word;

    tb_clk_gen #(.PERIOD_NS(20.0)) clk_gen_inst (.o_clk(FPGA_SYS_CLK));

    tsn_phy_mgmt_top UUT (
        .FPGA_SYS_CLK  (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N(FPGA_SYS_RST_N),
        .i_phy_mdio_i  (i_phy_mdio_i),
        .o_phy_rst_n   (o_phy_rst_n),
        .o_phy_mdc     (o_phy_mdc),
        .o_phy_mdio_o  (o_phy_mdio_o),
        .o_phy_mdio_oe (o_phy_mdio_oe),
        .o_init_done   (o_init_done)
    );

    task automatic fail_stop(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string sig, input int exp_val, input int act_val);
        $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, sig, exp_val, act_val);
        fail_stop("frame field differs from table");
    endtask

    // decode one finished frame by fields
    task automatic check_frame();
        if (frame_word.f.start != MDIO_START) mismatch("start", MDIO_START, frame_word.f.start);
        if (frame_word.f.phy_addr != PHY_ADDR)
            mismatch("phy_addr", PHY_ADDR, frame_word.f.phy_addr);
        if (rd_frame) begin
            if (wr_cnt < INIT_WRITES) fail_stop("status read before init table finished");
            if (frame_word.f.reg_addr != REG_BMSR)
                mismatch("reg_addr", REG_BMSR, frame_word.f.reg_addr);
        end else begin
            if (frame_word.f.op != MDIO_OP_WRITE) mismatch("op", MDIO_OP_WRITE, frame_word.f.op);
            if (wr_cnt >= INIT_WRITES || rd_cnt != 0) fail_stop("unexpected extra write frame");
            if (frame_word.f.reg_addr != INIT_REG[wr_cnt])
                mismatch("reg_addr", INIT_REG[wr_cnt], frame_word.f.reg_addr);
            if (frame_word.f.ta != MDIO_TA_WRITE) mismatch("ta", MDIO_TA_WRITE, frame_word.f.ta);
            if (frame_word.f.data != INIT_DATA[wr_cnt])
                mismatch("data", INIT_DATA[wr_cnt], frame_word.f.data);
            wr_cnt++;
        end
    endtask

    // phy model, one bit per mdc rise
    always @(posedge o_phy_mdc) begin
        bus_bit = o_phy_mdio_oe ? o_phy_mdio_o : i_phy_mdio_i;
        if (o_init_done) fail_stop("mdc activity after init done");
        if (bit_idx == 0) rd_frame = 1'b0;
        if (!(rd_frame && bit_idx >= MDIO_RELEASE_POS) && !o_phy_mdio_oe)
            fail_stop("master not driving mdio where it should");
        if (bit_idx < MDIO_PREAMBLE_BITS) begin
            if (bus_bit !== 1'b1) mismatch("preamble", 1, bus_bit);
        end else begin
            frame_word.raw = {frame_word.raw[MDIO_FRAME_BITS-2:0], bus_bit};
        end
        if (bit_idx == 35 && frame_word.raw[1:0] == MDIO_OP_READ) begin
            rd_frame = 1'b1;
            rd_cnt++;
            reply = (rd_cnt <= n_busy) ? BMSR_BUSY : BMSR_DONE;
        end
        if (rd_frame && bit_idx >= MDIO_RELEASE_POS && bit_idx < MDIO_TOTAL_BITS - 1)
            mdio_next = reply[MDIO_TOTAL_BITS - 2 - bit_idx];
        else
            mdio_next = 1'b1;                                // pull-up idle
        if (bit_idx == MDIO_TOTAL_BITS - 1) begin
            check_frame();
            bit_idx = 0;
        end else begin
            bit_idx++;
        end
    end

    always @(negedge FPGA_SYS_CLK) begin
        i_phy_mdio_i <= mdio_next;
        if (UUT.mdio_chk.fail_cnt != 0) fail_stop("concurrent assertion failed");
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge FPGA_SYS_CLK);
        fail_stop("timeout waiting for init done");
    end

    initial begin
        FPGA_SYS_RST_N = 1'b0;
        i_phy_mdio_i   = 1'b1;
        n_busy = ($unsigned($random(seed)) % 4) + 1;
        repeat (RST_CYCLES) @(negedge FPGA_SYS_CLK);
        FPGA_SYS_RST_N = 1'b1;
        wait (o_init_done === 1'b1);
        if (rd_cnt != n_busy + 1) mismatch("bmsr_reads", n_busy + 1, rd_cnt);
        repeat (2000) @(posedge FPGA_SYS_CLK);
        if (wr_cnt == INIT_WRITES && UUT.mdio_chk.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop("missing writes or assertion failure at end of run");
        end
    end

endmodule

//--- all.f
mdio_frame_pkg.sv
phy_board_pkg.sv
phy_init_seq.sv
mdio_master.sv
phy_pin_ctrl.sv
tsn_phy_mgmt_top.sv
tb_mdio_assertions.sv
tb_tsn_phy_mgmt.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tsn_phy_mgmt
DUT_TOP   ?= tsn_phy_mgmt_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
